/* include/cal_video_consts.svh */
`ifndef CAL_VIDEO_CONSTS_SVH
`define CAL_VIDEO_CONSTS_SVH

// horizontal timing, in pixels
`define H_ACTIVE 256
`define H_FRONT 8
`define H_SYNC 16
`define H_BACK 20
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing, in lines
`define V_ACTIVE 144
`define V_FRONT 3
`define V_SYNC 4
`define V_BACK 9
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// frame buffer size in pixels, shown at 4x
`define FB_WIDTH 64
`define FB_HEIGHT 32
`define SCALE_SHIFT 2

`define COLOR_WIDTH 8
// quotient width of the centroid divider
`define DIV_BITS 12

// counter and buffer coordinate widths
`define HCOUNT_WIDTH 9
`define VCOUNT_WIDTH 8
`define FB_X_WIDTH 6
`define FB_Y_WIDTH 5

`endif

/* hw/video_pkg.sv */
`include "cal_video_consts.svh"

package video_pkg;

    // screen position counters, blanking included
    typedef logic [`HCOUNT_WIDTH-1:0] hcount_t;
    typedef logic [`VCOUNT_WIDTH-1:0] vcount_t;

    // timing bundle that travels next to each pixel down the pipeline
    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    hsync;
        logic    vsync;
        logic    active;
        // high on the last active pixel only
        logic    frame_end;
    } video_timing_t;

endpackage

/* hw/pixel_pkg.sv */
`include "cal_video_consts.svh"

package pixel_pkg;

    typedef logic [`COLOR_WIDTH-1:0] color_t;

    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } rgb_t;

    // buffer coordinates and the flat address built as {y, x}
    typedef logic [`FB_X_WIDTH-1:0] fb_x_t;
    typedef logic [`FB_Y_WIDTH-1:0] fb_y_t;
    typedef logic [`FB_X_WIDTH+`FB_Y_WIDTH-1:0] fb_addr_t;

    // one camera write, already in buffer coordinates
    typedef struct packed {
        fb_x_t x;
        fb_y_t y;
        rgb_t  rgb;
    } cam_pixel_t;

    // bit0 from red, bit1 from blue
    typedef struct packed {
        logic bit1;
        logic bit0;
    } mask_t;

    typedef enum logic {CAMERA_VIEW, MASK_VIEW} view_t;

    typedef enum logic [1:0] {IDLE, DIVIDE_X, DIVIDE_Y} div_state_t;

endpackage

/* hw/video_timing.sv */
`timescale 1ns/1ps
`include "cal_video_consts.svh"

module video_timing (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    output video_pkg::video_timing_t timing
);
    import video_pkg::*;

    hcount_t hcount;
    vcount_t vcount;

    // pixel counter wraps at the line total, line counter at the frame total
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == hcount_t'(`H_TOTAL - 1)) begin
            hcount <= '0;
            if (vcount == vcount_t'(`V_TOTAL - 1)) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // decoded straight from the counters
    always_comb begin
        timing.hcount    = hcount;
        timing.vcount    = vcount;
        // sync pulses are active high, after the front porch
        timing.hsync     = (hcount >= hcount_t'(`H_ACTIVE + `H_FRONT))
                        && (hcount < hcount_t'(`H_ACTIVE + `H_FRONT + `H_SYNC));
        timing.vsync     = (vcount >= vcount_t'(`V_ACTIVE + `V_FRONT))
                        && (vcount < vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC));
        timing.active    = (hcount < hcount_t'(`H_ACTIVE)) && (vcount < vcount_t'(`V_ACTIVE));
        timing.frame_end = (hcount == hcount_t'(`H_ACTIVE - 1))
                        && (vcount == vcount_t'(`V_ACTIVE - 1));
    end

endmodule

/* hw/scan_reader.sv */
`timescale 1ns/1ps
`include "cal_video_consts.svh"

module scan_reader (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  video_pkg::video_timing_t timing,
    output logic                     rd_en,
    output pixel_pkg::fb_addr_t      rd_addr,
    output logic                     in_buffer,
    output video_pkg::video_timing_t timing_out
);
    import pixel_pkg::*;
    import video_pkg::*;

    fb_x_t         buf_x;
    fb_y_t         buf_y;
    logic          in_area;
    video_timing_t timing_q;

    always_comb begin
        // mirrored column: screen left maps to the right edge of the buffer
        buf_x = fb_x_t'(`FB_WIDTH - 1) - fb_x_t'(timing.hcount >> `SCALE_SHIFT);
        buf_y = fb_y_t'(timing.vcount >> `SCALE_SHIFT);
        // scaled buffer covers 256x128, the rest of the active area is black
        in_area = timing.active
               && (timing.hcount < hcount_t'(`FB_WIDTH << `SCALE_SHIFT))
               && (timing.vcount < vcount_t'(`FB_HEIGHT << `SCALE_SHIFT));
    end

    // stage 1 presents the read, stage 2 lines up with rd_data
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            rd_en      <= 1'b0;
            timing_q   <= '0;
            in_buffer  <= 1'b0;
            timing_out <= '0;
        end else begin
            rd_en      <= in_area;
            timing_q   <= timing;
            // rd_en doubles as the stage-1 copy of in_area
            in_buffer  <= rd_en;
            timing_out <= timing_q;
        end
    end

    // y times 64 plus x is just the concatenation
    always_ff @(posedge clk_pixel) begin
        rd_addr <= {buf_y, buf_x};
    end

endmodule

/* hw/frame_store.sv */
`timescale 1ns/1ps
`include "cal_video_consts.svh"

module frame_store (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  logic                  cam_valid,
    input  pixel_pkg::cam_pixel_t cam_pixel,
    output logic                  cam_ready,
    input  logic                  rd_en,
    input  pixel_pkg::fb_addr_t   rd_addr,
    output pixel_pkg::rgb_t       rd_data
);
    import pixel_pkg::*;

    // 64x32 pixels, one port shared by the scan and the camera
    rgb_t     mem [`FB_WIDTH * `FB_HEIGHT];
    fb_addr_t cam_addr;

    // reads always win, camera stalls for exactly the read cycles
    assign cam_ready = !rd_en;
    assign cam_addr  = {cam_pixel.y, cam_pixel.x};

    always_ff @(posedge clk_pixel) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end else if (cam_valid && !recent_reset) begin
            // cam_ready is high here, so this is the handshake
            mem[cam_addr] <= cam_pixel.rgb;
        end
    end

endmodule

/* hw/mask_detect.sv */
`timescale 1ns/1ps

module mask_detect (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  pixel_pkg::rgb_t          pixel,
    input  pixel_pkg::color_t        lower_threshold,
    input  video_pkg::video_timing_t timing_in,
    input  logic                     in_buffer_in,
    output pixel_pkg::mask_t         mask,
    output pixel_pkg::rgb_t          pixel_out,
    output video_pkg::video_timing_t timing_out,
    output logic                     in_buffer_out
);

    // timing and buffer flag follow the mask by one stage
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            timing_out    <= '0;
            in_buffer_out <= 1'b0;
        end else begin
            timing_out    <= timing_in;
            in_buffer_out <= in_buffer_in;
        end
    end

    // upper bound is full scale, so only the lower bound is compared
    // outside the buffer rd_data is stale, keep the mask clear there
    always_ff @(posedge clk_pixel) begin
        mask.bit0 <= in_buffer_in && (pixel.red >= lower_threshold);
        mask.bit1 <= in_buffer_in && (pixel.blue >= lower_threshold);
        // camera view copy, same stage as the mask
        pixel_out <= pixel;
    end

endmodule

/* hw/centroid_tracker.sv */
`timescale 1ns/1ps
`include "cal_video_consts.svh"

module centroid_tracker (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  pixel_pkg::mask_t         mask,
    input  video_pkg::video_timing_t timing,
    output video_pkg::hcount_t       centroid_x,
    output video_pkg::vcount_t       centroid_y,
    output logic                     centroid_valid
);
    import pixel_pkg::*;
    import video_pkg::*;

    // one frame has at most 256x144 hits, coordinates below 256
    localparam int COUNT_W = 16;
    localparam int SUM_W   = 24;
    // divisor shifted up by the top quotient bit
    localparam int DSR_W   = COUNT_W + `DIV_BITS - 1;
    localparam int STEP_W  = $clog2(`DIV_BITS);

    logic                 hit;
    logic [COUNT_W-1:0]   count;
    logic [COUNT_W-1:0]   count_next;
    logic [SUM_W-1:0]     sum_x;
    logic [SUM_W-1:0]     sum_x_next;
    logic [SUM_W-1:0]     sum_y;
    logic [SUM_W-1:0]     sum_y_next;
    // divider working registers
    logic [COUNT_W-1:0]   divisor;
    logic [SUM_W-1:0]     sum_y_hold;
    logic [SUM_W-1:0]     rem;
    logic [DSR_W-1:0]     dsr;
    logic [`DIV_BITS-1:0] quot;
    logic [`DIV_BITS-1:0] quot_next;
    logic [STEP_W-1:0]    step;
    logic                 fits;
    hcount_t              x_result;
    div_state_t           state;

    always_comb begin
        hit        = timing.active && mask.bit1;
        sum_x_next = sum_x + (hit ? SUM_W'(timing.hcount) : '0);
        sum_y_next = sum_y + (hit ? SUM_W'(timing.vcount) : '0);
        count_next = count + COUNT_W'(hit);
        // restoring step: subtract the shifted divisor when it fits
        fits       = DSR_W'(rem) >= dsr;
        quot_next  = {quot[`DIV_BITS-2:0], fits};
    end

    // per-frame accumulators, cleared once the last pixel is taken
    always_ff @(posedge clk_pixel) begin
        if (recent_reset || timing.frame_end) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else begin
            sum_x <= sum_x_next;
            sum_y <= sum_y_next;
            count <= count_next;
        end
    end

    // x first, then y; an empty frame never leaves IDLE
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state          <= IDLE;
            centroid_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (timing.frame_end && count_next != '0) begin
                        state <= DIVIDE_X;
                    end
                end
                DIVIDE_X: begin
                    if (step == '0) begin
                        state <= DIVIDE_Y;
                    end
                end
                DIVIDE_Y: begin
                    if (step == '0) begin
                        state          <= IDLE;
                        centroid_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (state == IDLE) begin
            // loaded every idle cycle, only the frame_end load matters
            // closing sums include the frame_end pixel itself
            rem        <= sum_x_next;
            sum_y_hold <= sum_y_next;
            divisor    <= count_next;
            dsr        <= DSR_W'(count_next) << (`DIV_BITS - 1);
            step       <= STEP_W'(`DIV_BITS - 1);
            quot       <= '0;
        end else begin
            if (fits) begin
                rem <= rem - SUM_W'(dsr);
            end
            dsr  <= dsr >> 1;
            quot <= quot_next;
            step <= step - 1'b1;
            if (step == '0) begin
                // reload for the y divide, same divisor
                rem  <= sum_y_hold;
                dsr  <= DSR_W'(divisor) << (`DIV_BITS - 1);
                step <= STEP_W'(`DIV_BITS - 1);
                quot <= '0;
                if (state == DIVIDE_X) begin
                    x_result <= quot_next[`HCOUNT_WIDTH-1:0];
                end else begin
                    // both results land together
                    centroid_x <= x_result;
                    centroid_y <= quot_next[`VCOUNT_WIDTH-1:0];
                end
            end
        end
    end

endmodule

/* hw/overlay_mux.sv */
`timescale 1ns/1ps

module overlay_mux (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  pixel_pkg::rgb_t          pixel,
    input  pixel_pkg::mask_t         mask,
    input  logic                     in_buffer,
    input  video_pkg::video_timing_t timing,
    input  pixel_pkg::view_t         view,
    input  logic                     crosshair_en,
    input  video_pkg::hcount_t       centroid_x,
    input  video_pkg::vcount_t       centroid_y,
    input  logic                     centroid_valid,
    output pixel_pkg::rgb_t          out_rgb,
    output video_pkg::video_timing_t out_timing
);
    import pixel_pkg::*;

    rgb_t mask_rgb;
    rgb_t next_rgb;
    logic on_cross;

    always_comb begin
        // mask view: full red for bit0, full blue for bit1
        mask_rgb.red   = mask.bit0 ? '1 : '0;
        mask_rgb.green = '0;
        mask_rgb.blue  = mask.bit1 ? '1 : '0;
        on_cross = crosshair_en && centroid_valid
                && ((timing.hcount == centroid_x) || (timing.vcount == centroid_y));
        // crosshair also runs through the rows below the buffer
        if (!timing.active) begin
            next_rgb = '0;
        end else if (on_cross) begin
            next_rgb = '1;
        end else if (!in_buffer) begin
            next_rgb = '0;
        end else if (view == MASK_VIEW) begin
            next_rgb = mask_rgb;
        end else begin
            next_rgb = pixel;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            out_timing <= '0;
        end else begin
            out_timing <= timing;
        end
    end

    always_ff @(posedge clk_pixel) begin
        out_rgb <= next_rgb;
    end

endmodule

/* hw/cal_pixel_top.sv */
`timescale 1ns/1ps

module cal_pixel_top (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  logic                     cam_valid,
    input  pixel_pkg::cam_pixel_t    cam_pixel,
    output logic                     cam_ready,
    input  pixel_pkg::color_t        lower_threshold,
    input  pixel_pkg::view_t         view,
    input  logic                     crosshair_en,
    output pixel_pkg::rgb_t          out_rgb,
    output video_pkg::video_timing_t out_timing
);
    import pixel_pkg::*;
    import video_pkg::*;

    // timing at t, t+2 and t+3
    video_timing_t gen_timing;
    video_timing_t rd_timing;
    video_timing_t mask_timing;
    // buffer read port
    logic          rd_en;
    fb_addr_t      rd_addr;
    rgb_t          rd_data;
    logic          rd_in_buffer;
    // mask stage
    logic          mask_in_buffer;
    rgb_t          mask_pixel;
    mask_t         mask;
    // last finished centroid
    hcount_t       centroid_x;
    vcount_t       centroid_y;
    logic          centroid_valid;

    video_timing timing_gen (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .timing      (gen_timing)
    );

    scan_reader reader (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .timing      (gen_timing),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .in_buffer   (rd_in_buffer),
        .timing_out  (rd_timing)
    );

    frame_store store (
        .clk_pixel   (clk_pixel),
        .recent_reset(recent_reset),
        .cam_valid   (cam_valid),
        .cam_pixel   (cam_pixel),
        .cam_ready   (cam_ready),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    mask_detect detect (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .pixel          (rd_data),
        .lower_threshold(lower_threshold),
        .timing_in      (rd_timing),
        .in_buffer_in   (rd_in_buffer),
        .mask           (mask),
        .pixel_out      (mask_pixel),
        .timing_out     (mask_timing),
        .in_buffer_out  (mask_in_buffer)
    );

    centroid_tracker tracker (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .mask          (mask),
        .timing        (mask_timing),
        .centroid_x    (centroid_x),
        .centroid_y    (centroid_y),
        .centroid_valid(centroid_valid)
    );

    overlay_mux overlay (
        .clk_pixel     (clk_pixel),
        .recent_reset  (recent_reset),
        .pixel         (mask_pixel),
        .mask          (mask),
        .in_buffer     (mask_in_buffer),
        .timing        (mask_timing),
        .view          (view),
        .crosshair_en  (crosshair_en),
        .centroid_x    (centroid_x),
        .centroid_y    (centroid_y),
        .centroid_valid(centroid_valid),
        .out_rgb       (out_rgb),
        .out_timing    (out_timing)
    );

endmodule

/* verification/cal_pixel_props.sv */
`timescale 1ns/1ps

module cal_pixel_props (
    input logic                     clk_pixel,
    input logic                     recent_reset,
    input logic                     cam_ready,
    input logic                     rd_en,
    input video_pkg::video_timing_t out_timing,
    input logic                     centroid_valid
);

    // reads win the single port, camera sees back-pressure
    read_blocks_camera: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        rd_en |-> !cam_ready
    ) else $error("cam_ready high during a buffer read");

    // syncs only in blanking
    sync_outside_active: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        out_timing.active |-> !(out_timing.hsync || out_timing.vsync)
    ) else $error("sync pulse inside the active area");

    // once a centroid exists it is only ever replaced
    centroid_valid_sticky: assert property (
        @(posedge clk_pixel) disable iff (recent_reset)
        centroid_valid |=> centroid_valid
    ) else $error("centroid_valid fell after being set");

endmodule

// attached to every cal_pixel_top instance
bind cal_pixel_top cal_pixel_props props (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .cam_ready     (cam_ready),
    .rd_en         (rd_en),
    .out_timing    (out_timing),
    .centroid_valid(centroid_valid)
);

/* verification/tb_cal_pixel_top.sv */
`timescale 1ns/1ps
`include "cal_video_consts.svh"

module tb_cal_pixel_top;
    import pixel_pkg::*;
    import video_pkg::*;

    localparam int FB_PIXELS    = `FB_WIDTH * `FB_HEIGHT;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    // a write waits out one line of reads at most
    localparam int WRITE_LIMIT  = 2 * `H_TOTAL;
    localparam int FRAME_LIMIT  = 2 * FRAME_CYCLES;
    // camera, mask 128, mask 64, crosshair, empty, held crosshair
    localparam int CHECK_FRAMES = 6;

    logic          clk_pixel;
    logic          recent_reset;
    logic          cam_valid;
    cam_pixel_t    cam_pixel;
    logic          cam_ready;
    color_t        lower_threshold;
    view_t         view;
    logic          crosshair_en;
    rgb_t          out_rgb;
    video_timing_t out_timing;

    // stored image indexed y*64+x like the buffer
    rgb_t img [FB_PIXELS];

    logic check_on;
    int   pixel_errors;
    int   timing_errors;
    int   other_errors;
    int   frames_timed;
    // model centroid taken from the last checked frame with hits
    logic model_valid;
    int   model_cx;
    int   model_cy;
    rgb_t exp_rgb;
    int   hit_count;
    int   hit_cx;
    int   hit_cy;
    // timing monitor state
    int   active_run;
    int   hsync_run;
    int   vsync_run;
    int   line_count;
    logic prev_active;
    logic prev_hsync;
    logic prev_vsync;
    logic prev_cvalid;

    cal_pixel_top DUT (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .cam_valid      (cam_valid),
        .cam_pixel      (cam_pixel),
        .cam_ready      (cam_ready),
        .lower_threshold(lower_threshold),
        .view           (view),
        .crosshair_en   (crosshair_en),
        .out_rgb        (out_rgb),
        .out_timing     (out_timing)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // screen to buffer at 4x scale with mirrored columns
    function automatic int buffer_index(input int h, input int v);
        return (v >> `SCALE_SHIFT) * `FB_WIDTH + (`FB_WIDTH - 1 - (h >> `SCALE_SHIFT));
    endfunction

    // expected display pixel for one output position
    function automatic rgb_t expected_pixel(input video_timing_t t, input color_t thr,
                                            input view_t vw, input logic xh_en);
        rgb_t px;
        rgb_t res;
        int   h;
        int   v;
        h   = int'(t.hcount);
        v   = int'(t.vcount);
        res = '0;
        if (t.active) begin
            if (xh_en && model_valid && (h == model_cx || v == model_cy)) begin
                // crosshair wins over everything in the active area
                res = '1;
            end else if (v < (`FB_HEIGHT << `SCALE_SHIFT)) begin
                px = img[buffer_index(h, v)];
                if (vw == MASK_VIEW) begin
                    res.red  = (px.red >= thr) ? 8'hff : 8'h00;
                    res.blue = (px.blue >= thr) ? 8'hff : 8'h00;
                end else begin
                    res = px;
                end
            end
        end
        return res;
    endfunction

    // floor centre of mass of blue hits over the scaled buffer area
    function automatic void frame_centroid(input color_t thr, output int n,
                                           output int cx, output int cy);
        longint sx;
        longint sy;
        rgb_t   px;
        n  = 0;
        sx = 0;
        sy = 0;
        for (int v = 0; v < (`FB_HEIGHT << `SCALE_SHIFT); v++) begin
            for (int h = 0; h < (`FB_WIDTH << `SCALE_SHIFT); h++) begin
                px = img[buffer_index(h, v)];
                if (px.blue >= thr) begin
                    n++;
                    sx += h;
                    sy += v;
                end
            end
        end
        cx = (n > 0) ? int'(sx / n) : 0;
        cy = (n > 0) ? int'(sy / n) : 0;
    endfunction

    task automatic build_image();
        logic [31:0] seed;
        seed = 32'h88c13847;
        for (int i = 0; i < FB_PIXELS; i++) begin
            seed = lcg_next(seed);
            img[i].red   = seed[31:24];
            img[i].green = seed[23:16];
            // no full-scale blue, so threshold 255 leaves no bit-1 pixel
            img[i].blue  = (seed[15:8] == 8'hff) ? 8'hfe : seed[15:8];
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d pixel, %0d timing, %0d other",
                 pixel_errors, timing_errors, other_errors);
        if (pixel_errors + timing_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        other_errors++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // one pixel per handshake, held while cam_ready is low
    task automatic write_image();
        cam_pixel_t next_px;
        int         guard;
        logic       accepted;
        for (int i = 0; i < FB_PIXELS; i++) begin
            next_px.x   = fb_x_t'(i % `FB_WIDTH);
            next_px.y   = fb_y_t'(i / `FB_WIDTH);
            next_px.rgb = img[i];
            cam_valid <= 1'b1;
            cam_pixel <= next_px;
            guard    = 0;
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk_pixel);
                accepted = cam_ready;
                guard++;
                if (!accepted && guard > WRITE_LIMIT) begin
                    abort_on_timeout("a camera write to be accepted");
                end
            end
        end
        cam_valid <= 1'b0;
    endtask

    task automatic wait_frame_end();
        int   guard;
        logic seen;
        guard = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(posedge clk_pixel);
            seen = out_timing.frame_end;
            guard++;
            if (!seen && guard > FRAME_LIMIT) begin
                abort_on_timeout("the end of a frame on out_timing");
            end
        end
    endtask

    // every output cycle against the model
    always @(posedge clk_pixel) begin
        if (check_on) begin
            exp_rgb = expected_pixel(out_timing, lower_threshold, view, crosshair_en);
            assert (out_rgb === exp_rgb) else begin
                pixel_errors++;
                $display("Mismatch at %0t: pixel (%0d,%0d) is %h, expected %h", $time,
                         out_timing.hcount, out_timing.vcount, out_rgb, exp_rgb);
            end
            // frame just ended sets the crosshair of the next one
            if (out_timing.frame_end) begin
                frame_centroid(lower_threshold, hit_count, hit_cx, hit_cy);
                if (hit_count > 0) begin
                    model_valid = 1'b1;
                    model_cx    = hit_cx;
                    model_cy    = hit_cy;
                end
            end
        end
    end

    // line and frame shape as seen on out_timing
    always @(posedge clk_pixel) begin
        if (!recent_reset) begin
            if (out_timing.active) begin
                active_run++;
            end else if (prev_active) begin
                assert (active_run == `H_ACTIVE) else begin
                    timing_errors++;
                    $display("Mismatch at %0t: line had %0d active pixels, expected %0d",
                             $time, active_run, `H_ACTIVE);
                end
                active_run = 0;
                line_count++;
            end
            if (out_timing.hsync) begin
                hsync_run++;
            end else if (prev_hsync) begin
                assert (hsync_run == `H_SYNC) else begin
                    timing_errors++;
                    $display("Mismatch at %0t: hsync lasted %0d cycles, expected %0d",
                             $time, hsync_run, `H_SYNC);
                end
                hsync_run = 0;
            end
            if (out_timing.vsync) begin
                if (!prev_vsync) begin
                    assert (line_count == `V_ACTIVE) else begin
                        timing_errors++;
                        $display("Mismatch at %0t: frame had %0d active lines, expected %0d",
                                 $time, line_count, `V_ACTIVE);
                    end
                    line_count = 0;
                end
                vsync_run++;
            end else if (prev_vsync) begin
                assert (vsync_run == `V_SYNC * `H_TOTAL) else begin
                    timing_errors++;
                    $display("Mismatch at %0t: vsync lasted %0d cycles, expected %0d",
                             $time, vsync_run, `V_SYNC * `H_TOTAL);
                end
                vsync_run = 0;
                frames_timed++;
            end
            // frame_end only on the last active pixel
            if (out_timing.frame_end) begin
                assert (out_timing.active
                        && out_timing.hcount == hcount_t'(`H_ACTIVE - 1)
                        && out_timing.vcount == vcount_t'(`V_ACTIVE - 1)) else begin
                    timing_errors++;
                    $display("Mismatch at %0t: frame_end at (%0d,%0d), expected (%0d,%0d)",
                             $time, out_timing.hcount, out_timing.vcount,
                             `H_ACTIVE - 1, `V_ACTIVE - 1);
                end
            end
            assert (!(out_timing.active && (out_timing.hsync || out_timing.vsync))) else begin
                timing_errors++;
                $display("A sync pulse was high inside the active area at %0t", $time);
            end
            assert (!(DUT.rd_en && cam_ready)) else begin
                other_errors++;
                $display("The camera port was ready during a buffer read at %0t", $time);
            end
            assert (!(prev_cvalid && !DUT.centroid_valid)) else begin
                other_errors++;
                $display("The centroid valid flag dropped at %0t", $time);
            end
            prev_active = out_timing.active;
            prev_hsync  = out_timing.hsync;
            prev_vsync  = out_timing.vsync;
            prev_cvalid = DUT.centroid_valid;
        end
    end

    initial begin
        recent_reset    = 1'b1;
        cam_valid       = 1'b0;
        cam_pixel       = '0;
        lower_threshold = 8'd128;
        view            = CAMERA_VIEW;
        crosshair_en    = 1'b0;
        check_on        = 1'b0;
        pixel_errors    = 0;
        timing_errors   = 0;
        other_errors    = 0;
        frames_timed    = 0;
        model_valid     = 1'b0;
        model_cx        = 0;
        model_cy        = 0;
        active_run      = 0;
        hsync_run       = 0;
        vsync_run       = 0;
        line_count      = 0;
        prev_active     = 1'b0;
        prev_hsync      = 1'b0;
        prev_vsync      = 1'b0;
        prev_cvalid     = 1'b0;
        build_image();
        repeat (4) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        // written while video runs, stalled by the scan reads
        write_image();
        // frame in flight may still hold old data
        wait_frame_end();
        check_on <= 1'b1;
        // config only changes right after an output frame_end, in blanking
        wait_frame_end();
        view <= MASK_VIEW;
        wait_frame_end();
        lower_threshold <= 8'd64;
        wait_frame_end();
        view         <= CAMERA_VIEW;
        crosshair_en <= 1'b1;
        wait_frame_end();
        // nothing reaches 255 in blue so the centroid must hold
        lower_threshold <= 8'hff;
        view            <= MASK_VIEW;
        wait_frame_end();
        wait_frame_end();
        // let the compare process finish the last frame_end
        @(posedge clk_pixel);
        assert (frames_timed >= CHECK_FRAMES) else begin
            other_errors++;
            $display("Only %0d frames had their timing checked", frames_timed);
        end
        finish_run();
    end

endmodule

/* verilog.f */
+incdir+include
hw/video_pkg.sv
hw/pixel_pkg.sv
hw/video_timing.sv
hw/scan_reader.sv
hw/frame_store.sv
hw/mask_detect.sv
hw/centroid_tracker.sv
hw/overlay_mux.sv
hw/cal_pixel_top.sv
verification/cal_pixel_props.sv
verification/tb_cal_pixel_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_cal_pixel_top \
    --Mdir "$BUILD_DIR" -o sim_cal_pixel
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# assertion errors must not stop the run before the testbench summary
"./$BUILD_DIR/sim_cal_pixel" +verilator+error+limit+1000000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0
